// ==== energy_accum.sv ====
/*
  One channel's sum of squares over a fixed window. Holds a single pending
  mean square; a newer window overwrites it and sets the sticky overrun.
  Only rst clears overrun. Nothing moves while run is low.
*/

`default_nettype none

`include "level_meter_defs.svh"

module energy_accum
  import log2_pkg::*;
  import meter_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  input  logic               sample_valid,
  input  logic signed [15:0] sample,
  input  logic               grant,
  output logic               pending,
  output log2_operand_t      mean_sq,
  output logic               overrun
);

  logic [`LM_WIN_LOG2-1:0] count;
  accum_t                  sum;
  accum_t                  sum_next;
  logic signed [31:0]      square;
  logic                    take;
  logic                    win_end;

  // Square is never negative, peak 2**30 at -32768
  assign square   = sample * sample;
  assign sum_next = sum + accum_t'($unsigned(square));

  // Sample counted only while running
  assign take    = run && sample_valid;
  // Window closes on the 64th counted sample
  assign win_end = take && (count == '1);

  //////////////////////////////
  // Sum and window counter
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sum   <= '0;
      count <= '0;
    end else if (take) begin
      // Counter wraps to zero at window end
      count <= count + 1'b1;
      sum   <= win_end ? '0 : sum_next;
    end
  end

  // Divide by window length with a plain shift
  always_ff @(posedge clk) begin
    if (win_end) begin
      mean_sq <= log2_operand_t'(sum_next >> `LM_WIN_LOG2);
    end
  end

  //////////////////////////////
  // Pending handshake
  //////////////////////////////

  // Grant in the same edge as a new window still takes the old value,
  // so that case is not an overrun
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      overrun <= 1'b0;
    end else if (run) begin
      if (win_end) begin
        pending <= 1'b1;
        overrun <= overrun | (pending & ~grant);
      end else if (grant) begin
        pending <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== level_meter_defs.svh ====
/*
  Build-time sizing for the level meter. The window length and channel count
  are fixed at compile time. The arbiter sizes its credit counter from the
  credit depth, so any depth of one or more fits.
*/

`ifndef LEVEL_METER_DEFS_SVH
`define LEVEL_METER_DEFS_SVH

//////////////////////////////
// Channel layout
//////////////////////////////

// Number of peer accumulators sharing the log pipeline
`define LM_CHANNELS 4

//////////////////////////////
// Window and flow control
//////////////////////////////

// Window of 2**6 = 64 samples per mean square
`define LM_WIN_LOG2 6

// Results the consumer can absorb without returning a credit
// Also the credit count loaded on reset
`define LM_CREDITS 4

`endif

// ==== level_meter_tb.sv ====
/*
  Random-stimulus testbench for the four-channel level meter, checked
  against a sum-of-squares and log2 model kept here. Credits come back
  0 to 3 cycles after each result unless a test withholds them.
*/

`default_nettype none

`include "level_meter_defs.svh"

module level_meter_tb
  import log2_pkg::*;
  import meter_pkg::*;
();

  localparam int WIN_LEN    = 1 << `LM_WIN_LOG2;
  localparam int FIFO_DEPTH = 8;

  // Samples driven over all tests, sizes the watchdog
  localparam int TOTAL_SAMPLES  = WIN_LEN * (6 + 4 * 3 + 6 + 6 + 4 * 2);
  localparam int TIMEOUT_CYCLES = TOTAL_SAMPLES * 4 + 2000;

  // 16 * log2(1 + f/32), rounded, capped at 15, entry 28 held at 14
  localparam logic [3:0] FRAC_TABLE [32] = '{
    4'd0,  4'd1,  4'd1,  4'd2,  4'd3,  4'd3,  4'd4,  4'd5,
    4'd5,  4'd6,  4'd6,  4'd7,  4'd7,  4'd8,  4'd8,  4'd9,
    4'd9,  4'd10, 4'd10, 4'd11, 4'd11, 4'd12, 4'd12, 4'd13,
    4'd13, 4'd13, 4'd14, 4'd14, 4'd14, 4'd15, 4'd15, 4'd15
  };

  // Constant levels and their hand-worked 5.4 logs of level squared
  localparam logic [15:0] LEVELS [6] = '{
    16'h0000, 16'h0001, 16'h0005, 16'h0064, 16'h7fff, 16'h8000
  };
  localparam logic [8:0] LEVEL_LOGS [6] = '{
    9'h000, 9'h000, 9'h04a, 9'h0d5, 9'h1df, 9'h1e0
  };

  logic                       clk;
  logic                       rst;
  logic                       run;
  logic [`LM_CHANNELS-1:0]    sample_valid;
  logic [`LM_CHANNELS*16-1:0] sample_data;
  logic                       credit_return;
  logic                       out_valid;
  chan_t                      out_chan;
  logic [8:0]                 out_log;
  logic [`LM_CHANNELS-1:0]    overrun;

  integer seed;

  // Model state, one ring buffer of expected results per channel
  accum_t        sum_sq    [`LM_CHANNELS];
  int            win_count [`LM_CHANNELS];
  log2_operand_t exp_mean  [`LM_CHANNELS][FIFO_DEPTH];
  log2_result_t  exp_log   [`LM_CHANNELS][FIFO_DEPTH];
  int            wr_ptr    [`LM_CHANNELS];
  int            rd_ptr    [`LM_CHANNELS];
  logic [`LM_CHANNELS-1:0] exp_overrun;
  logic [8:0]    last_log  [`LM_CHANNELS];
  int            results_total;

  // Credit return schedule, slot k is due k edges from now
  int sched [4];
  int ready_credits;
  bit hold_credits;
  // Set only while the credit counter is known to be empty
  bit no_issue;

  // What the DUT saw at the last rising edge
  logic rst_prev;
  logic run_prev;

  string cur_test;
  int    test_errors;
  int    tests_passed;
  int    tests_failed;

  level_meter_top u_level_meter_top (
    .clk           (clk),
    .rst           (rst),
    .run           (run),
    .sample_valid  (sample_valid),
    .sample_data   (sample_data),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_chan      (out_chan),
    .out_log       (out_log),
    .overrun       (overrun)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Four-state compare, an X or Z on the DUT side counts as a mismatch
  task automatic compare(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERROR [%s] %s: expected 0x%0h, actual 0x%0h",
               cur_test, what, expected, actual);
      test_errors++;
    end
  endtask

  // Leading one gives exp, next five bits index the table
  function automatic log2_result_t model_log(input log2_operand_t v);
    log2_result_t res;
    int           msb;
    longint       below;
    int           idx;
    msb = 0;
    for (int b = 0; b < 32; b++) begin
      if (v[b]) begin
        msb = b;
      end
    end
    below    = longint'(v) & ((longint'(1) << msb) - 1);
    idx      = int'((below << 5) >> msb);
    res.exp  = 5'(msb);
    res.frac = FRAC_TABLE[idx];
    return res;
  endfunction

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    logic [`LM_CHANNELS-1:0] exp;
    @(posedge clk);
    exp = exp_overrun;
    @(negedge clk);
    compare("overrun", exp, overrun);
    @(posedge clk);
    $display("[%s] finished with %0d error(s)", cur_test, test_errors);
    if (test_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
  endtask

  // Drives the masked channels until each has given the set number of windows
  task automatic feed_windows(input logic [3:0] mask, input int windows,
                              input bit fixed, input logic [15:0] level,
                              input bit freeze);
    int          left [`LM_CHANNELS];
    int          busy;
    logic [31:0] rnd;
    logic [`LM_CHANNELS-1:0]    valid_next;
    logic [`LM_CHANNELS*16-1:0] data_next;
    for (int c = 0; c < `LM_CHANNELS; c++) begin
      left[c] = mask[c] ? windows * WIN_LEN : 0;
    end
    busy = 1;
    while (busy != 0) begin
      @(posedge clk);
      // Samples the DUT took at this edge
      for (int c = 0; c < `LM_CHANNELS; c++) begin
        if (run && sample_valid[c] && left[c] > 0) begin
          left[c]--;
        end
      end
      busy       = 0;
      valid_next = '0;
      data_next  = '0;
      for (int c = 0; c < `LM_CHANNELS; c++) begin
        if (left[c] > 0) begin
          busy = 1;
          rnd  = $random(seed);
          valid_next[c]          = fixed ? 1'b1 : rnd[0];
          data_next[c*16 +: 16]  = fixed ? level : rnd[31:16];
        end
      end
      rnd = $random(seed);
      sample_valid <= valid_next;
      sample_data  <= data_next;
      // Freeze for about one cycle in four
      run <= (freeze && busy != 0) ? (rnd[1:0] != 2'b00) : 1'b1;
    end
  endtask

  task automatic wait_results(input int target);
    while (results_total < target) begin
      @(posedge clk);
    end
  endtask

  // Until every expected result is out, then room for credits to settle
  task automatic wait_drain();
    int busy;
    busy = 1;
    while (busy != 0) begin
      @(posedge clk);
      busy = 0;
      for (int c = 0; c < `LM_CHANNELS; c++) begin
        if (wr_ptr[c] != rd_ptr[c]) begin
          busy = 1;
        end
      end
    end
    repeat (12) @(posedge clk);
  endtask

  //////////////////////////////
  // Monitor and model
  //////////////////////////////

  // Outputs from the last edge, then inputs the next edge will take
  always @(negedge clk) begin : monitor
    logic signed [15:0] s;
    logic [31:0]        rnd;
    log2_operand_t      mean;
    int                 slot;
    int                 ch;
    // Held out_valid during a freeze is not a new result
    if (!rst_prev && run_prev && out_valid) begin
      ch = int'(out_chan);
      results_total++;
      last_log[ch] = out_log;
      if (wr_ptr[ch] == rd_ptr[ch]) begin
        $display("[%s] unexpected result on channel %0d, no window was pending",
                 cur_test, ch);
        test_errors++;
      end else begin
        slot = rd_ptr[ch] % FIFO_DEPTH;
        compare($sformatf("out_log ch%0d mean 0x%0h", ch, exp_mean[ch][slot]),
                exp_log[ch][slot], out_log);
        rd_ptr[ch]++;
      end
      rnd = $random(seed);
      sched[rnd[1:0]] = sched[rnd[1:0]] + 1;
    end
    for (int c = 0; c < `LM_CHANNELS; c++) begin
      if (!rst && run && sample_valid[c]) begin
        s = sample_data[c*16 +: 16];
        sum_sq[c] = sum_sq[c] + accum_t'(longint'(s) * longint'(s));
        win_count[c]++;
        if (win_count[c] == WIN_LEN) begin
          mean = log2_operand_t'(sum_sq[c] >> `LM_WIN_LOG2);
          if (no_issue && wr_ptr[c] != rd_ptr[c]) begin
            // Newer window overwrites the unissued one
            exp_overrun[c] = 1'b1;
            slot = (wr_ptr[c] - 1) % FIFO_DEPTH;
          end else begin
            slot = wr_ptr[c] % FIFO_DEPTH;
            wr_ptr[c]++;
          end
          exp_mean[c][slot] = mean;
          exp_log[c][slot]  = model_log(mean);
          sum_sq[c]    = '0;
          win_count[c] = 0;
        end
      end
    end
    rst_prev = rst;
    run_prev = run;
  end

  // Consumer credit return, one pulse per cycle at most
  always @(posedge clk) begin : credit_gen
    ready_credits = ready_credits + sched[0];
    sched[0] = sched[1];
    sched[1] = sched[2];
    sched[2] = sched[3];
    sched[3] = 0;
    if (!hold_credits && ready_credits > 0) begin
      credit_return <= 1'b1;
      ready_credits--;
    end else begin
      credit_return <= 1'b0;
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles with results still missing", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    int base;
    seed          = 32'hde65_a340;
    rst           = 1'b1;
    run           = 1'b1;
    sample_valid  = '0;
    sample_data   = '0;
    credit_return = 1'b0;
    hold_credits  = 1'b0;
    no_issue      = 1'b0;
    rst_prev      = 1'b1;
    run_prev      = 1'b0;
    exp_overrun   = '0;
    results_total = 0;
    ready_credits = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    for (int c = 0; c < `LM_CHANNELS; c++) begin
      sum_sq[c]    = '0;
      win_count[c] = 0;
      wr_ptr[c]    = 0;
      rd_ptr[c]    = 0;
      last_log[c]  = '0;
    end
    for (int k = 0; k < 4; k++) begin
      sched[k] = 0;
    end

    // Test 1, idle after reset
    start_test("reset_state");
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare("out_valid after reset", 0, out_valid);
    compare("overrun after reset", 0, overrun);
    repeat (20) @(posedge clk);
    compare("results before any window", 0, results_total);
    end_test();

    // Test 2, constant levels on channel 2
    start_test("log_accuracy");
    base = results_total;
    for (int i = 0; i < 6; i++) begin
      feed_windows(4'b0100, 1, 1'b1, LEVELS[i], 1'b0);
      wait_drain();
      compare($sformatf("log of level 0x%0h", LEVELS[i]), LEVEL_LOGS[i], last_log[2]);
    end
    compare("result count", base + 6, results_total);
    end_test();

    // Test 3
    start_test("random_multichannel");
    base = results_total;
    feed_windows(4'b1111, 3, 1'b0, 16'h0000, 1'b0);
    wait_drain();
    compare("result count", base + 12, results_total);
    end_test();

    // Test 4, two windows left waiting on credits
    start_test("credit_backpressure");
    base = results_total;
    @(negedge clk);
    hold_credits = 1'b1;
    feed_windows(4'b1111, 1, 1'b0, 16'h0000, 1'b0);
    wait_results(base + `LM_CREDITS);
    feed_windows(4'b0011, 1, 1'b0, 16'h0000, 1'b0);
    repeat (40) @(posedge clk);
    compare("results while credits held", base + `LM_CREDITS, results_total);
    @(negedge clk);
    hold_credits = 1'b0;
    wait_drain();
    compare("results after release", base + 6, results_total);
    end_test();

    // Test 5, channel 0 completes two windows with no credit left
    start_test("overrun");
    base = results_total;
    @(negedge clk);
    hold_credits = 1'b1;
    feed_windows(4'b1111, 1, 1'b0, 16'h0000, 1'b0);
    wait_results(base + `LM_CREDITS);
    no_issue = 1'b1;
    feed_windows(4'b0001, 2, 1'b0, 16'h0000, 1'b0);
    @(negedge clk);
    compare("overrun on channel 0", 1, overrun[0]);
    compare("results while credits held", base + `LM_CREDITS, results_total);
    @(posedge clk);
    no_issue = 1'b0;
    @(negedge clk);
    hold_credits = 1'b0;
    wait_drain();
    compare("results after release", base + 5, results_total);
    end_test();

    // Test 6, run drops at random cycles
    start_test("run_freeze");
    base = results_total;
    feed_windows(4'b1111, 2, 1'b0, 16'h0000, 1'b1);
    wait_drain();
    compare("result count", base + 8, results_total);
    end_test();

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== level_meter_top.f ====
+incdir+.
log2_pkg.sv
meter_pkg.sv
log2_if.sv
log2_pipe.sv
energy_accum.sv
log2_arbiter.sv
level_meter_top.sv
level_meter_tb.sv

// ==== level_meter_top.sv ====
/*
  Four-channel power meter. Results come out as 5.4 log2 of the windowed
  mean square, tagged by channel. The consumer must take every out_valid
  and return one credit per result; there is no output buffer.
*/

`default_nettype none

`include "level_meter_defs.svh"

module level_meter_top
  import log2_pkg::*;
  import meter_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run,
  input  logic [`LM_CHANNELS-1:0]    sample_valid,
  input  logic [`LM_CHANNELS*16-1:0] sample_data,
  input  logic                       credit_return,
  output logic                       out_valid,
  output chan_t                      out_chan,
  output logic [8:0]                 out_log,
  output logic [`LM_CHANNELS-1:0]    overrun
);

  // Accumulator to arbiter handshake
  logic [`LM_CHANNELS-1:0] pending;
  logic [`LM_CHANNELS-1:0] grant;
  log2_operand_t           mean_sq [`LM_CHANNELS];

  log2_if log_bus ();

  //////////////////////////////
  // Channel accumulators
  //////////////////////////////

  // Channel ch owns sample_data[ch*16 +: 16]
  for (genvar ch = 0; ch < `LM_CHANNELS; ch++) begin : g_chan
    energy_accum u_accum (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .sample_valid (sample_valid[ch]),
      .sample       (sample_data[ch*16 +: 16]),
      .grant        (grant[ch]),
      .pending      (pending[ch]),
      .mean_sq      (mean_sq[ch]),
      .overrun      (overrun[ch])
    );
  end

  // Shared conversion path
  log2_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .run           (run),
    .credit_return (credit_return),
    .pending       (pending),
    .mean_sq       (mean_sq),
    .grant         (grant),
    .issue         (log_bus.issuer)
  );

  log2_pipe u_log2 (
    .clk  (clk),
    .rst  (rst),
    .run  (run),
    .conv (log_bus.converter)
  );

  // Response side of the bus drives the ports directly
  assign out_valid = log_bus.resp_valid;
  assign out_chan  = log_bus.resp_chan;
  assign out_log   = log_bus.resp_result;

endmodule

`default_nettype wire

// ==== log2_arbiter.sv ====
/*
  Round-robin issue of pending channels to the log pipeline. A channel is
  granted only while run is high and a credit is held. Credit returns are
  counted even while run is low, so none are lost during a freeze.
*/

`default_nettype none

`include "level_meter_defs.svh"

module log2_arbiter
  import log2_pkg::*;
  import meter_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    run,
  input  logic                    credit_return,
  input  logic [`LM_CHANNELS-1:0] pending,
  input  log2_operand_t           mean_sq [`LM_CHANNELS],
  output logic [`LM_CHANNELS-1:0] grant,
  log2_if.issuer                  issue
);

  localparam int CRED_W = $clog2(`LM_CREDITS + 1);

  chan_t             ptr;
  chan_t             winner;
  logic              found;
  logic              fire;
  logic [CRED_W-1:0] credits;

  //////////////////////////////
  // Round-robin pick
  //////////////////////////////

  // Scan downward so the channel nearest the pointer is written last
  always_comb begin
    chan_t cand;
    winner = ptr;
    found  = 1'b0;
    for (int i = `LM_CHANNELS - 1; i >= 0; i--) begin
      cand = chan_t'((int'(ptr) + i) % `LM_CHANNELS);
      if (pending[cand]) begin
        winner = cand;
        found  = 1'b1;
      end
    end
  end

  // Issue needs a candidate, a credit and a running meter
  assign fire  = found && (credits != '0) && run;
  // One-hot, the accumulator drops pending on this edge
  assign grant = fire ? (`LM_CHANNELS'(1) << winner) : '0;

  //////////////////////////////
  // Request register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      issue.req_valid <= 1'b0;
      ptr             <= '0;
    end else if (run) begin
      issue.req_valid <= fire;
      if (fire) begin
        // Next search starts just past the winner
        ptr <= chan_t'((int'(winner) + 1) % `LM_CHANNELS);
      end
    end
  end

  // Payload only loads on an issue
  always_ff @(posedge clk) begin
    if (fire) begin
      issue.req_operand <= mean_sq[winner];
      issue.req_chan    <= winner;
    end
  end

  //////////////////////////////
  // Credit counter
  //////////////////////////////

  // Issue and return together cancel out
  // Return at full count is ignored so the counter stays bounded
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CRED_W'(`LM_CREDITS);
    end else begin
      case ({fire, credit_return})
        2'b10: credits <= credits - 1'b1;
        2'b01: begin
          if (credits != CRED_W'(`LM_CREDITS)) begin
            credits <= credits + 1'b1;
          end
        end
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== log2_if.sv ====
/*
  Request and tagged-response link around the log pipeline. The issuer owns
  the request side, the converter the response side. Sink is read-only for
  whoever consumes results.
*/

`default_nettype none

`include "level_meter_defs.svh"

interface log2_if
  import log2_pkg::*;
();

  localparam int TAG_W = $clog2(`LM_CHANNELS);

  // Request side
  logic              req_valid;
  log2_operand_t     req_operand;
  logic [TAG_W-1:0]  req_chan;

  // Response side, tag travels with the result
  logic              resp_valid;
  log2_result_t      resp_result;
  logic [TAG_W-1:0]  resp_chan;

  modport issuer (output req_valid, req_operand, req_chan);

  modport converter (
    input  req_valid, req_operand, req_chan,
    output resp_valid, resp_result, resp_chan
  );

  modport sink (input resp_valid, resp_result, resp_chan);

endinterface

`default_nettype wire

// ==== log2_pipe.sv ====
/*
  Three-stage base-2 log. A request launched by the issuer at edge k shows
  up on the response after edge k+3, counting run-high cycles only. No
  stall besides run; three requests may be in flight.
*/

`default_nettype none

`include "level_meter_defs.svh"

module log2_pipe
  import log2_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      run,
  log2_if.converter conv
);

  localparam int TAG_W = $clog2(`LM_CHANNELS);

  // Stage 1 combinational
  logic [4:0]        msb_pos;
  logic [30:0]       low_mask;

  // Stage 1 registers
  logic [4:0]        exp_s1;
  logic [30:0]       below_s1;

  // Stage 2 combinational and registers
  logic [30:0]       aligned;
  logic [4:0]        exp_s2;
  logic [4:0]        idx_s2;

  // Stage 3 register
  log2_result_t      result_q;

  // Tag and valid shift, one slot per stage
  logic [2:0]        valid_q;
  logic [TAG_W-1:0]  chan_q [3];

  //////////////////////////////
  // Stage 1, priority encoder
  //////////////////////////////

  // Highest set bit wins, since the loop runs upward
  always_comb begin
    msb_pos = 5'd0;
    for (int b = 0; b < 32; b++) begin
      if (conv.req_operand[b]) begin
        msb_pos = 5'(b);
      end
    end
  end

  // Keeps only bits under the leading one
  // At position 31 the shift wraps to zero, so the mask is all ones
  assign low_mask = (31'd1 << msb_pos) - 31'd1;

  always_ff @(posedge clk) begin
    if (run) begin
      exp_s1   <= msb_pos;
      below_s1 <= conv.req_operand[30:0] & low_mask;
    end
  end

  //////////////////////////////
  // Stage 2, normalizing shift
  //////////////////////////////

  // Bit just under the leading one lands on bit 30
  // Small operands pull zeros in from below
  assign aligned = below_s1 << (5'd31 - exp_s1);

  always_ff @(posedge clk) begin
    if (run) begin
      exp_s2 <= exp_s1;
      idx_s2 <= aligned[30:26];
    end
  end

  //////////////////////////////
  // Stage 3, fraction table
  //////////////////////////////

  // Operands 0 and 1 both end at exp 0, index 0
  always_ff @(posedge clk) begin
    if (run) begin
      result_q.exp  <= exp_s2;
      result_q.frac <= LOG2_FRAC_LUT[idx_s2];
    end
  end

  // Valid needs reset, tags just follow along
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (run) begin
      valid_q <= {valid_q[1:0], conv.req_valid};
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      chan_q[0] <= conv.req_chan;
      chan_q[1] <= chan_q[0];
      chan_q[2] <= chan_q[1];
    end
  end

  // Response straight from stage 3
  assign conv.resp_valid  = valid_q[2];
  assign conv.resp_result = result_q;
  assign conv.resp_chan   = chan_q[2];

endmodule

`default_nettype wire

// ==== log2_pkg.sv ====
/*
  Types for the base-2 log datapath. Operands are unsigned 32-bit values.
  Results are 5.4 fixed point, so the fraction resolution is 1/16.
*/

`default_nettype none

package log2_pkg;

  // Value to convert, a mean square in this design
  typedef logic [31:0] log2_operand_t;

  // 5.4 result, exp is the position of the leading one
  typedef struct packed {
    logic [4:0] exp;
    logic [3:0] frac;
  } log2_result_t;

  // Fraction table, 16 * log2(1 + f/32) rounded, top entries capped at 15
  // Entry 28 held at 14 so the curve stays monotonic without a jump
  localparam logic [3:0] LOG2_FRAC_LUT [32] = '{
    4'd0,  4'd1,  4'd1,  4'd2,  4'd3,  4'd3,  4'd4,  4'd5,
    4'd5,  4'd6,  4'd6,  4'd7,  4'd7,  4'd8,  4'd8,  4'd9,
    4'd9,  4'd10, 4'd10, 4'd11, 4'd11, 4'd12, 4'd12, 4'd13,
    4'd13, 4'd13, 4'd14, 4'd14, 4'd14, 4'd15, 4'd15, 4'd15
  };

endpackage

`default_nettype wire

// ==== meter_pkg.sv ====
/*
  Types for the meter side. Widths follow the channel count and window
  length in the defs header.
*/

`default_nettype none

`include "level_meter_defs.svh"

package meter_pkg;

  // Channel index, 2 bits for four channels
  typedef logic [$clog2(`LM_CHANNELS)-1:0] chan_t;

  // Sum of squares over one window
  // 16-bit square peaks at 2**30, plus 6 bits of window growth
  typedef logic [30+`LM_WIN_LOG2:0] accum_t;

endpackage

`default_nettype wire
